/* design/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  rv32i_types_pkg::alu_op_t alu_op_i,
    input  logic [XLEN-1:0]          a_i,
    input  logic [XLEN-1:0]          b_i,
    output logic [XLEN-1:0]          f_o
);
    import rv32i_types_pkg::*;

    logic [4:0] shamt;

    // rv32i shifts use only the low five bits
    assign shamt = b_i[4:0];

    always_comb begin
        case (alu_op_i)
            alu_add:    f_o = a_i + b_i;
            alu_sub:    f_o = a_i - b_i;
            alu_sll:    f_o = a_i << shamt;
            alu_slt:    f_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            alu_sltu:   f_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            alu_xor:    f_o = a_i ^ b_i;
            alu_srl:    f_o = a_i >> shamt;
            alu_sra:    f_o = $unsigned($signed(a_i) >>> shamt);
            alu_or:     f_o = a_i | b_i;
            alu_and:    f_o = a_i & b_i;
            alu_pass_b: f_o = b_i;
            default:    f_o = '0;
        endcase
    end

endmodule : alu

/* design/branch_cmp.sv */
`timescale 1ns/1ps

module branch_cmp #(
    parameter int XLEN = 32
) (
    input  rv32i_types_pkg::cmp_op_t cmp_op_i,
    input  logic [XLEN-1:0]          a_i,
    input  logic [XLEN-1:0]          b_i,
    output logic                     br_en_o
);
    import rv32i_types_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmp_op_i)
            beq:     br_en_o = eq;
            bne:     br_en_o = !eq;
            blt:     br_en_o = lt_s;
            bge:     br_en_o = !lt_s;
            bltu:    br_en_o = lt_u;
            bgeu:    br_en_o = !lt_u;
            default: br_en_o = 1'b0;
        endcase
    end

endmodule : branch_cmp

/* design/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve #(
    parameter int XLEN = 32
) (
    input  logic                   valid_i,
    input  ex_mux_pkg::flow_kind_t flow_kind_i,
    input  logic                   pred_taken_i,
    input  logic                   br_en_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [XLEN-1:0]        alu_out_i,
    output logic [XLEN-1:0]        rd_data_o,
    output logic                   taken_o,
    output logic                   redirect_o,
    output logic [XLEN-1:0]        redirect_pc_o
);
    import ex_mux_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic            is_jump;

    assign pc_plus4 = pc_i + XLEN'(4);
    assign is_jump  = (flow_kind_i == flow_jal) || (flow_kind_i == flow_jalr);

    always_comb begin
        case (flow_kind_i)
            flow_branch: taken_o = br_en_i;
            flow_jal:    taken_o = 1'b1;
            flow_jalr:   taken_o = 1'b1;
            default:     taken_o = 1'b0;
        endcase
    end

    // jalr target has its low bit forced to zero
    always_comb begin
        target = alu_out_i;
        if (flow_kind_i == flow_jalr) begin
            target[0] = 1'b0;
        end
    end

    // fetch guessed wrong, either direction
    assign redirect_o = valid_i && (taken_o != pred_taken_i);

    // not taken means fall through to the next instruction
    assign redirect_pc_o = taken_o ? target : pc_plus4;

    // jumps write the link address
    assign rd_data_o = is_jump ? pc_plus4 : alu_out_i;

endmodule : branch_resolve

/* design/ex_mux_pkg.sv */
package ex_mux_pkg;

    // where a register operand is taken from
    // the hazard unit picks one per operand
    typedef enum logic [2:0] {
        // value read from the register file in decode
        fwd_id_ex        = 3'd0,
        // alu result of the instruction in mem
        fwd_ex_mem       = 3'd1,
        // write-back data of the instruction in wb
        fwd_mem_wb       = 3'd2,
        // u immediate of the instruction in mem (lui)
        fwd_u_imm_ex_mem = 3'd3,
        // u immediate of the instruction in wb
        fwd_u_imm_mem_wb = 3'd4,
        // slt-style flag results, zero-extended
        fwd_br_en_ex_mem = 3'd5,
        fwd_br_en_mem_wb = 3'd6
    } fwd_sel_t;

    // first alu operand
    typedef enum logic [1:0] {
        mux1_rs1  = 2'd0,
        // auipc, jal
        mux1_pc   = 2'd1,
        // lui
        mux1_zero = 2'd2
    } alumux1_sel_t;

    // second alu operand
    typedef enum logic [2:0] {
        // decoded immediate, format already chosen by decode
        mux2_imm  = 3'd0,
        mux2_rs2  = 3'd1,
        mux2_four = 3'd2
    } alumux2_sel_t;

    // control flow class, drives branch resolution
    typedef enum logic [1:0] {
        flow_seq    = 2'd0,
        flow_branch = 2'd1,
        flow_jal    = 2'd2,
        flow_jalr   = 2'd3
    } flow_kind_t;

endpackage : ex_mux_pkg

/* design/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage #(
    parameter int XLEN = 32
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         valid_i,
    input  logic                         stall_i,
    input  logic [XLEN-1:0]              pc_i,
    input  logic [XLEN-1:0]              rs1_data_i,
    input  logic [XLEN-1:0]              rs2_data_i,
    input  logic [XLEN-1:0]              imm_i,
    input  logic [XLEN-1:0]              u_imm_i,
    input  rv32i_types_pkg::reg_idx_t    rs1_i,
    input  rv32i_types_pkg::reg_idx_t    rs2_i,
    input  rv32i_types_pkg::reg_idx_t    rd_i,
    input  rv32i_types_pkg::alu_op_t     alu_op_i,
    input  rv32i_types_pkg::cmp_op_t     cmp_op_i,
    input  ex_mux_pkg::alumux1_sel_t     alumux1_sel_i,
    input  ex_mux_pkg::alumux2_sel_t     alumux2_sel_i,
    input  ex_mux_pkg::flow_kind_t       flow_kind_i,
    input  logic                         load_regfile_i,
    input  logic                         mem_read_i,
    input  logic                         mem_write_i,
    input  logic                         pred_taken_i,
    input  ex_mux_pkg::fwd_sel_t         fwd_a_i,
    input  ex_mux_pkg::fwd_sel_t         fwd_b_i,
    input  logic [XLEN-1:0]              mem_alu_out_i,
    input  logic [XLEN-1:0]              mem_u_imm_i,
    input  logic                         mem_br_en_i,
    input  logic [XLEN-1:0]              wb_data_i,
    input  logic [XLEN-1:0]              wb_u_imm_i,
    input  logic                         wb_br_en_i,
    output logic                         ex_valid_o,
    output logic [XLEN-1:0]              alu_out_o,
    output logic [XLEN-1:0]              rd_data_o,
    output logic [XLEN-1:0]              store_data_o,
    output rv32i_types_pkg::reg_idx_t    rd_o,
    output logic                         load_regfile_o,
    output logic                         mem_read_o,
    output logic                         mem_write_o,
    output logic                         br_en_o,
    output logic                         redirect_o,
    output logic [XLEN-1:0]              redirect_pc_o
);
    import rv32i_types_pkg::*;
    import ex_mux_pkg::*;

    // decoded instruction as held in ID/EX
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] u_imm;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
        alu_op_t         alu_op;
        cmp_op_t         cmp_op;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        flow_kind_t      flow_kind;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        logic            pred_taken;
        fwd_sel_t        fwd_a;
        fwd_sel_t        fwd_b;
    } id_ex_t;

    // execute results as held in EX/MEM
    typedef struct packed {
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] rd_data;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] redirect_pc;
        reg_idx_t        rd;
        logic            br_en;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        logic            redirect;
    } ex_mem_t;

    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    logic            id_ex_valid;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    logic            ex_fire;
    logic [XLEN-1:0] rs1_rf;
    logic [XLEN-1:0] rs2_rf;
    logic [XLEN-1:0] imm_sel;
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] redirect_pc;
    logic            br_en;
    logic            redirect;

    always_comb begin
        id_ex_d.pc           = pc_i;
        id_ex_d.rs1_data     = rs1_data_i;
        id_ex_d.rs2_data     = rs2_data_i;
        id_ex_d.imm          = imm_i;
        id_ex_d.u_imm        = u_imm_i;
        id_ex_d.rs1          = rs1_i;
        id_ex_d.rs2          = rs2_i;
        id_ex_d.rd           = rd_i;
        id_ex_d.alu_op       = alu_op_i;
        id_ex_d.cmp_op       = cmp_op_i;
        id_ex_d.alumux1_sel  = alumux1_sel_i;
        id_ex_d.alumux2_sel  = alumux2_sel_i;
        id_ex_d.flow_kind    = flow_kind_i;
        id_ex_d.load_regfile = load_regfile_i;
        id_ex_d.mem_read     = mem_read_i;
        id_ex_d.mem_write    = mem_write_i;
        id_ex_d.pred_taken   = pred_taken_i;
        id_ex_d.fwd_a        = fwd_a_i;
        id_ex_d.fwd_b        = fwd_b_i;
    end

    // stall freezes the instruction sitting in EX
    pipe_reg #(
        .PAYLOAD_T(id_ex_t)
    ) u_id_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (stall_i),
        .bubble_i (1'b0),
        .valid_i  (valid_i),
        .data_i   (id_ex_d),
        .valid_o  (id_ex_valid),
        .data_o   (id_ex_q)
    );

    // instruction leaves EX this cycle
    assign ex_fire = id_ex_valid && !stall_i;

    // x0 always reads as zero
    assign rs1_rf = (id_ex_q.rs1 == '0) ? '0 : id_ex_q.rs1_data;
    assign rs2_rf = (id_ex_q.rs2 == '0) ? '0 : id_ex_q.rs2_data;

    // lui takes the u immediate straight through
    assign imm_sel = (id_ex_q.alu_op == alu_pass_b) ? id_ex_q.u_imm : id_ex_q.imm;

    operand_forward #(
        .XLEN(XLEN)
    ) u_operand_forward (
        .fwd_a_i       (id_ex_q.fwd_a),
        .fwd_b_i       (id_ex_q.fwd_b),
        .rs1_data_i    (rs1_rf),
        .rs2_data_i    (rs2_rf),
        .pc_i          (id_ex_q.pc),
        .imm_i         (imm_sel),
        .mem_alu_out_i (mem_alu_out_i),
        .mem_u_imm_i   (mem_u_imm_i),
        .wb_data_i     (wb_data_i),
        .wb_u_imm_i    (wb_u_imm_i),
        .mem_br_en_i   (mem_br_en_i),
        .wb_br_en_i    (wb_br_en_i),
        .alumux1_sel_i (id_ex_q.alumux1_sel),
        .alumux2_sel_i (id_ex_q.alumux2_sel),
        .rs1_fwd_o     (rs1_fwd),
        .rs2_fwd_o     (rs2_fwd),
        .opa_o         (opa),
        .opb_o         (opb)
    );

    alu #(
        .XLEN(XLEN)
    ) u_alu (
        .alu_op_i (id_ex_q.alu_op),
        .a_i      (opa),
        .b_i      (opb),
        .f_o      (alu_out)
    );

    branch_cmp #(
        .XLEN(XLEN)
    ) u_branch_cmp (
        .cmp_op_i (id_ex_q.cmp_op),
        .a_i      (rs1_fwd),
        .b_i      (rs2_fwd),
        .br_en_o  (br_en)
    );

    branch_resolve #(
        .XLEN(XLEN)
    ) u_branch_resolve (
        .valid_i       (ex_fire),
        .flow_kind_i   (id_ex_q.flow_kind),
        .pred_taken_i  (id_ex_q.pred_taken),
        .br_en_i       (br_en),
        .pc_i          (id_ex_q.pc),
        .alu_out_i     (alu_out),
        .rd_data_o     (rd_data),
        .taken_o       (),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    // controls gated here so a bubble carries them low
    always_comb begin
        ex_mem_d.alu_out      = alu_out;
        ex_mem_d.rd_data      = rd_data;
        ex_mem_d.store_data   = rs2_fwd;
        ex_mem_d.redirect_pc  = redirect_pc;
        ex_mem_d.rd           = id_ex_q.rd;
        ex_mem_d.br_en        = br_en;
        ex_mem_d.load_regfile = id_ex_q.load_regfile && ex_fire;
        ex_mem_d.mem_read     = id_ex_q.mem_read && ex_fire;
        ex_mem_d.mem_write    = id_ex_q.mem_write && ex_fire;
        ex_mem_d.redirect     = redirect;
    end

    pipe_reg #(
        .PAYLOAD_T(ex_mem_t)
    ) u_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (stall_i),
        .valid_i  (id_ex_valid),
        .data_i   (ex_mem_d),
        .valid_o  (ex_valid_o),
        .data_o   (ex_mem_q)
    );

    assign alu_out_o      = ex_mem_q.alu_out;
    assign rd_data_o      = ex_mem_q.rd_data;
    assign store_data_o   = ex_mem_q.store_data;
    assign redirect_pc_o  = ex_mem_q.redirect_pc;
    assign rd_o           = ex_mem_q.rd;
    assign br_en_o        = ex_mem_q.br_en;
    assign load_regfile_o = ex_mem_q.load_regfile;
    assign mem_read_o     = ex_mem_q.mem_read;
    assign mem_write_o    = ex_mem_q.mem_write;
    assign redirect_o     = ex_mem_q.redirect;

endmodule : ex_stage

/* design/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward #(
    parameter int XLEN = 32
) (
    input  ex_mux_pkg::fwd_sel_t     fwd_a_i,
    input  ex_mux_pkg::fwd_sel_t     fwd_b_i,
    input  logic [XLEN-1:0]          rs1_data_i,
    input  logic [XLEN-1:0]          rs2_data_i,
    input  logic [XLEN-1:0]          pc_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [XLEN-1:0]          mem_alu_out_i,
    input  logic [XLEN-1:0]          mem_u_imm_i,
    input  logic [XLEN-1:0]          wb_data_i,
    input  logic [XLEN-1:0]          wb_u_imm_i,
    input  logic                     mem_br_en_i,
    input  logic                     wb_br_en_i,
    input  ex_mux_pkg::alumux1_sel_t alumux1_sel_i,
    input  ex_mux_pkg::alumux2_sel_t alumux2_sel_i,
    output logic [XLEN-1:0]          rs1_fwd_o,
    output logic [XLEN-1:0]          rs2_fwd_o,
    output logic [XLEN-1:0]          opa_o,
    output logic [XLEN-1:0]          opb_o
);
    import ex_mux_pkg::*;

    // same seven-way choice for both register operands
    function automatic logic [XLEN-1:0] fwd_pick(fwd_sel_t sel, logic [XLEN-1:0] rf_val);
        logic [XLEN-1:0] val;
        case (sel)
            fwd_id_ex:        val = rf_val;
            fwd_ex_mem:       val = mem_alu_out_i;
            fwd_mem_wb:       val = wb_data_i;
            fwd_u_imm_ex_mem: val = mem_u_imm_i;
            fwd_u_imm_mem_wb: val = wb_u_imm_i;
            fwd_br_en_ex_mem: val = {{(XLEN-1){1'b0}}, mem_br_en_i};
            fwd_br_en_mem_wb: val = {{(XLEN-1){1'b0}}, wb_br_en_i};
            default:          val = rf_val;
        endcase
        return val;
    endfunction

    always_comb begin
        rs1_fwd_o = fwd_pick(fwd_a_i, rs1_data_i);
        rs2_fwd_o = fwd_pick(fwd_b_i, rs2_data_i);
    end

    always_comb begin
        case (alumux1_sel_i)
            mux1_pc:   opa_o = pc_i;
            mux1_zero: opa_o = '0;
            default:   opa_o = rs1_fwd_o;
        endcase
        case (alumux2_sel_i)
            mux2_rs2:  opb_o = rs2_fwd_o;
            // return address for jal/jalr style sums
            mux2_four: opb_o = XLEN'(4);
            default:   opb_o = imm_i;
        endcase
    end

endmodule : operand_forward

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  logic     valid_i,
    input  PAYLOAD_T data_i,
    output logic     valid_o,
    output PAYLOAD_T data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else if (!hold_i) begin
            // a bubble still takes the payload, only valid drops
            valid_o <= valid_i && !bubble_i;
            data_o  <= data_i;
        end
    end

endmodule : pipe_reg

/* design/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    // alu operation select, set by decode
    typedef enum logic [3:0] {
        alu_add    = 4'h0,
        alu_sub    = 4'h1,
        alu_sll    = 4'h2,
        alu_slt    = 4'h3,
        alu_sltu   = 4'h4,
        alu_xor    = 4'h5,
        alu_srl    = 4'h6,
        alu_sra    = 4'h7,
        alu_or     = 4'h8,
        alu_and    = 4'h9,
        // result is operand b, used by lui
        alu_pass_b = 4'ha
    } alu_op_t;

    // branch compare, same encoding as the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    // architectural register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

endpackage : rv32i_types_pkg

/* files.f */
design/rv32i_types_pkg.sv
design/ex_mux_pkg.sv
design/pipe_reg.sv
design/operand_forward.sv
design/alu.sv
design/branch_cmp.sv
design/branch_resolve.sv
design/ex_stage.sv
sim/ex_stage_assert.sv
sim/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module ex_stage_tb -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_ex_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* sim/ex_stage_assert.sv */
`timescale 1ns/1ps

module ex_stage_assert #(
    parameter int XLEN = 32
) (
    input logic            clk,
    input logic            arst_n_i,
    input logic            stall_i,
    input logic            ex_valid_o,
    input logic [XLEN-1:0] alu_out_o,
    input logic            load_regfile_o,
    input logic            mem_read_o,
    input logic            mem_write_o,
    input logic            redirect_o
);

    // the asynchronous reset clears every control output
    reset_controls_low: assert property (@(posedge clk)
        !arst_n_i |-> !(ex_valid_o || load_regfile_o || mem_read_o || mem_write_o || redirect_o))
        else $error("control output high while reset is asserted");

    // a redirect only comes from a real instruction
    redirect_needs_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_o |-> ex_valid_o)
        else $error("redirect_o high without ex_valid_o");

    // stall puts a bubble into EX/MEM
    stall_gives_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> !ex_valid_o)
        else $error("ex_valid_o high after a stall edge");

    valid_result_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        ex_valid_o |-> !$isunknown(alu_out_o))
        else $error("alu_out_o unknown while ex_valid_o is high");

endmodule : ex_stage_assert

/* sim/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb;
    import rv32i_types_pkg::*;
    import ex_mux_pkg::*;

    localparam int XLEN = 32;
    localparam int MAX_LINES = 500;
    localparam int DRAIN_LIMIT = 10;

    // one output slot as expected by the vector file
    typedef struct packed {
        logic        valid;
        logic [31:0] alu;
        logic [31:0] rd;
        logic [31:0] sd;
        logic        br;
        logic        red;
        logic [31:0] rpc;
        logic [2:0]  ctl;
        logic [4:0]  dst;
    } exp_t;

    logic         clk;
    logic         arst_n_i;
    logic         valid;
    logic         stall;
    logic [31:0]  pc;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    logic [31:0]  imm;
    logic [31:0]  u_imm;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    alu_op_t      alu_op;
    cmp_op_t      cmp_op;
    alumux1_sel_t alumux1_sel;
    alumux2_sel_t alumux2_sel;
    flow_kind_t   flow_kind;
    logic         load_regfile;
    logic         mem_read;
    logic         mem_write;
    logic         pred_taken;
    fwd_sel_t     fwd_a;
    fwd_sel_t     fwd_b;
    logic [31:0]  mem_alu_out;
    logic [31:0]  mem_u_imm;
    logic         mem_br_en;
    logic [31:0]  wb_data;
    logic [31:0]  wb_u_imm;
    logic         wb_br_en;

    logic         ex_valid_o;
    logic [31:0]  alu_out_o;
    logic [31:0]  rd_data_o;
    logic [31:0]  store_data_o;
    reg_idx_t     rd_o;
    logic         load_regfile_o;
    logic         mem_read_o;
    logic         mem_write_o;
    logic         br_en_o;
    logic         redirect_o;
    logic [31:0]  redirect_pc_o;

    // fields of the current vector line
    logic        r_valid, r_stall, r_ld, r_mr, r_mw, r_pt, r_mbr, r_wbbr;
    logic [31:0] r_pc, r_rs1d, r_rs2d, r_imm, r_uimm, r_malu, r_mu, r_wbd, r_wbu;
    logic [4:0]  r_rs1, r_rs2, r_rd;
    logic [3:0]  r_aop;
    logic [2:0]  r_cop, r_m2, r_fa, r_fb;
    logic [1:0]  r_m1, r_fk;
    logic        e_valid, e_br, e_red;
    logic [31:0] e_alu, e_rd, e_sd, e_rpc;

    // forwarding values for the instruction that sits in EX next cycle
    logic [31:0] p_malu, p_mu, p_wbd, p_wbu;
    logic        p_mbr, p_wbbr;
    logic [2:0]  ex_ctl;
    logic [4:0]  ex_rd;

    exp_t   exp_q[$];
    integer seed;
    integer errors;
    integer checks;

    ex_stage #(
        .XLEN(XLEN)
    ) u_ex_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid),
        .stall_i        (stall),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .imm_i          (imm),
        .u_imm_i        (u_imm),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .rd_i           (rd),
        .alu_op_i       (alu_op),
        .cmp_op_i       (cmp_op),
        .alumux1_sel_i  (alumux1_sel),
        .alumux2_sel_i  (alumux2_sel),
        .flow_kind_i    (flow_kind),
        .load_regfile_i (load_regfile),
        .mem_read_i     (mem_read),
        .mem_write_i    (mem_write),
        .pred_taken_i   (pred_taken),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .mem_alu_out_i  (mem_alu_out),
        .mem_u_imm_i    (mem_u_imm),
        .mem_br_en_i    (mem_br_en),
        .wb_data_i      (wb_data),
        .wb_u_imm_i     (wb_u_imm),
        .wb_br_en_i     (wb_br_en),
        .ex_valid_o     (ex_valid_o),
        .alu_out_o      (alu_out_o),
        .rd_data_o      (rd_data_o),
        .store_data_o   (store_data_o),
        .rd_o           (rd_o),
        .load_regfile_o (load_regfile_o),
        .mem_read_o     (mem_read_o),
        .mem_write_o    (mem_write_o),
        .br_en_o        (br_en_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o)
    );

    bind ex_stage ex_stage_assert #(
        .XLEN(XLEN)
    ) u_ex_stage_assert (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_i),
        .ex_valid_o     (ex_valid_o),
        .alu_out_o      (alu_out_o),
        .load_regfile_o (load_regfile_o),
        .mem_read_o     (mem_read_o),
        .mem_write_o    (mem_write_o),
        .redirect_o     (redirect_o)
    );

    always #4 clk = ~clk;

    function automatic logic sel_uses(logic [2:0] k);
        return (r_fa == k) || (r_fb == k);
    endfunction

    task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_slot(exp_t e);
        logic [2:0] ctl;
        ctl = {load_regfile_o, mem_read_o, mem_write_o};
        check_field("ex_valid", 32'(ex_valid_o), 32'(e.valid));
        if (e.valid) begin
            check_field("alu_out", alu_out_o, e.alu);
            check_field("rd_data", rd_data_o, e.rd);
            check_field("store_data", store_data_o, e.sd);
            check_field("br_en", 32'(br_en_o), 32'(e.br));
            check_field("redirect", 32'(redirect_o), 32'(e.red));
            check_field("redirect_pc", redirect_pc_o, e.rpc);
            check_field("controls", 32'(ctl), 32'(e.ctl));
            check_field("rd", 32'(rd_o), 32'(e.dst));
        end else begin
            // bubble slot
            check_field("controls", 32'(ctl), 32'd0);
            check_field("redirect", 32'(redirect_o), 32'd0);
        end
    endtask

    task automatic drive_forward_values();
        mem_alu_out <= p_malu;
        mem_u_imm   <= p_mu;
        mem_br_en   <= p_mbr;
        wb_data     <= p_wbd;
        wb_u_imm    <= p_wbu;
        wb_br_en    <= p_wbbr;
    endtask

    // sources that no select points at get random values
    task automatic choose_forward_values();
        logic [31:0] rnd;
        rnd = $random(seed);
        p_malu = sel_uses(3'd1) ? r_malu : rnd;
        rnd = $random(seed);
        p_wbd = sel_uses(3'd2) ? r_wbd : rnd;
        rnd = $random(seed);
        p_mu = sel_uses(3'd3) ? r_mu : rnd;
        rnd = $random(seed);
        p_wbu = sel_uses(3'd4) ? r_wbu : rnd;
        rnd = $random(seed);
        p_mbr = sel_uses(3'd5) ? r_mbr : rnd[0];
        rnd = $random(seed);
        p_wbbr = sel_uses(3'd6) ? r_wbbr : rnd[0];
    endtask

    task automatic apply_row();
        valid        <= r_valid;
        stall        <= r_stall;
        pc           <= r_pc;
        rs1_data     <= r_rs1d;
        rs2_data     <= r_rs2d;
        imm          <= r_imm;
        u_imm        <= r_uimm;
        rs1          <= r_rs1;
        rs2          <= r_rs2;
        rd           <= r_rd;
        alu_op       <= alu_op_t'(r_aop);
        cmp_op       <= cmp_op_t'(r_cop);
        alumux1_sel  <= alumux1_sel_t'(r_m1);
        alumux2_sel  <= alumux2_sel_t'(r_m2);
        flow_kind    <= flow_kind_t'(r_fk);
        load_regfile <= r_ld;
        mem_read     <= r_mr;
        mem_write    <= r_mw;
        pred_taken   <= r_pt;
        fwd_a        <= fwd_sel_t'(r_fa);
        fwd_b        <= fwd_sel_t'(r_fb);
    endtask

    initial begin
        integer fd;
        integer code;
        integer n;
        integer lines;
        integer drain;
        string  line;
        exp_t   e;

        clk = 1'b0;
        arst_n_i = 1'b0;
        valid = 1'b0;
        stall = 1'b0;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm = '0;
        u_imm = '0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        alu_op = alu_add;
        cmp_op = beq;
        alumux1_sel = mux1_rs1;
        alumux2_sel = mux2_imm;
        flow_kind = flow_seq;
        load_regfile = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        pred_taken = 1'b0;
        fwd_a = fwd_id_ex;
        fwd_b = fwd_id_ex;
        mem_alu_out = '0;
        mem_u_imm = '0;
        mem_br_en = 1'b0;
        wb_data = '0;
        wb_u_imm = '0;
        wb_br_en = 1'b0;
        p_malu = '0;
        p_mu = '0;
        p_mbr = 1'b0;
        p_wbd = '0;
        p_wbu = '0;
        p_wbbr = 1'b0;
        ex_ctl = '0;
        ex_rd = '0;
        seed = 12153;
        errors = 0;
        checks = 0;

        fd = $fopen("sim/ex_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/ex_stimulus.txt");
            errors++;
        end

        repeat (16) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_field("ex_valid after reset", 32'(ex_valid_o), 32'd0);
        check_field("controls after reset",
                    32'({load_regfile_o, mem_read_o, mem_write_o, redirect_o}), 32'd0);

        lines = 0;
        if (fd != 0) begin
            while (!$feof(fd) && lines < MAX_LINES) begin
                lines++;
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                    continue;
                end
                n = $sscanf(line,
                    "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    r_valid, r_stall, r_pc, r_rs1d, r_rs2d,
                    r_imm, r_uimm, r_rs1, r_rs2, r_rd, r_aop, r_cop, r_m1, r_m2,
                    r_fk, r_ld, r_mr, r_mw, r_pt, r_fa, r_fb, r_malu, r_mu, r_mbr,
                    r_wbd, r_wbu, r_wbbr, e_valid, e_alu, e_rd, e_sd, e_br,
                    e_red, e_rpc);
                if (n != 34) begin
                    $display("vector line %0d has %0d fields instead of 34", lines, n);
                    errors++;
                    continue;
                end
                @(posedge clk);
                drive_forward_values();
                apply_row();
                // a stalled line leaves the held instruction in EX
                if (!r_stall) begin
                    ex_ctl = {r_ld, r_mr, r_mw};
                    ex_rd = r_rd;
                    choose_forward_values();
                end
                exp_q.push_back({e_valid, e_alu, e_rd, e_sd, e_br, e_red, e_rpc, ex_ctl, ex_rd});
                @(negedge clk);
                if (exp_q.size() > 2) begin
                    check_slot(exp_q.pop_front());
                end
            end
            if (lines >= MAX_LINES) begin
                $display("vector file did not end within %0d lines", MAX_LINES);
                errors++;
            end
            $fclose(fd);
        end

        // let the last instructions leave the pipeline
        drain = 0;
        while (exp_q.size() > 0 && drain < DRAIN_LIMIT) begin
            @(posedge clk);
            drive_forward_values();
            valid <= 1'b0;
            stall <= 1'b0;
            @(negedge clk);
            e = exp_q.pop_front();
            check_slot(e);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("pipeline did not drain within %0d cycles", DRAIN_LIMIT);
            errors++;
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : ex_stage_tb

/* sim/ex_stimulus.txt */
# v st pc rs1d rs2d imm uimm rs1 rs2 rd aop cop m1 m2 fk ld mr mw pt fa fb malu mu mbr wbd wbu wbbr
# then expected: ex_valid alu_out rd_data store_data br_en redirect redirect_pc (all hex)
1 0 100 5 3 0 0 1 2 3 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 8 8 3 0 0 104
1 0 104 3 5 0 0 1 2 3 1 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 fffffffe fffffffe 5 0 0 108
1 0 108 1 24 0 0 1 2 3 2 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 10 10 24 0 0 10c
1 0 10c ffffffff 1 0 0 1 2 3 3 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 0 0 110
1 0 110 ffffffff 1 0 0 1 2 3 4 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 114
1 0 114 f0f0f0f ff00ff 0 0 1 2 3 5 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 ff00ff0 ff00ff0 ff00ff 0 0 118
1 0 118 80000000 7 4 0 1 2 3 6 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 8000000 8000000 7 0 0 11c
1 0 11c 80000000 7 4 0 1 2 3 7 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 f8000000 f8000000 7 0 0 120
1 0 120 f0 f f 0 1 2 3 8 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 ff ff f 0 0 124
1 0 124 ff00 f0f0 0 0 1 2 3 9 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 f000 f000 f0f0 0 0 128
1 0 128 11111111 22222222 0 0 1 2 4 0 0 0 1 0 1 0 0 0 1 2 1000 0 0 20 0 0 1 1020 1020 20 0 0 12c
1 0 12c 11111111 22222222 0 0 1 2 4 0 0 0 1 0 1 0 0 0 3 4 0 12345000 0 0 678 0 1 12345678 12345678 678 0 0 130
1 0 130 11111111 22222222 0 0 1 2 4 0 0 0 1 0 1 0 0 0 5 6 0 0 1 0 0 1 1 2 2 1 1 0 134
1 0 134 200 0 10 0 1 2 0 0 0 0 0 0 0 0 1 0 0 1 abcd 0 0 0 0 0 1 210 210 abcd 0 0 138
1 0 138 7 7 40 0 1 2 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 178 178 7 1 1 178
1 0 13c 7 7 40 0 1 2 0 0 1 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 17c 17c 7 0 0 140
1 0 140 ffffffff 1 40 0 1 2 0 0 4 1 0 1 0 0 0 1 0 0 0 0 0 0 0 0 1 180 180 1 1 0 180
1 0 144 ffffffff 1 40 0 1 2 0 0 7 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 184 184 1 1 1 184
1 0 148 ffffffff 1 40 0 1 2 0 0 6 1 0 1 0 0 0 1 0 0 0 0 0 0 0 0 1 188 188 1 0 1 14c
1 0 14c 0 1 40 0 1 2 0 0 5 1 0 1 0 0 0 0 1 0 fffffff0 0 0 0 0 0 1 18c 18c 1 0 0 150
1 0 150 0 0 100 0 0 0 1 0 0 1 0 2 1 0 0 1 0 0 0 0 0 0 0 0 1 250 154 0 1 0 250
1 0 154 301 0 4 0 1 0 1 0 0 0 0 3 1 0 0 0 0 0 0 0 0 0 0 0 1 305 158 0 0 1 304
1 0 158 0 0 0 abcde000 0 0 5 a 0 2 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 abcde000 abcde000 0 1 0 15c
1 0 15c 0 0 1000 0 0 0 6 0 0 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 115c 115c 0 1 0 160
1 0 160 10 20 0 0 1 2 7 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 30 30 20 0 0 164
1 0 164 1 1 0 0 1 2 8 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 1 2 2 1 1 0 168
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
